//--- verilog/synth_pkg.sv
`default_nettype none

package synth_pkg;

    typedef logic [7:0]  sample_t;  // Unsigned, mid-scale at 128
    typedef logic [5:0]  note_t;    // 0 to 35, lowest C at 0
    typedef logic [31:0] period_t;  // Step period in clocks

    typedef enum logic [1:0] {
        WAVE_TRIANGLE = 2'd0,
        WAVE_SAWTOOTH = 2'd1,
        WAVE_SQUARE   = 2'd2,
        WAVE_SINE     = 2'd3
    } wave_t;

    typedef struct packed {
        note_t note;
        wave_t wave;
        logic  noise_en;
    } synth_cmd_t;

    localparam int          I2S_WORD_BITS = 16;
    localparam logic [15:0] NOISE_SEED    = 16'hACE1;  // Any nonzero value works

    localparam sample_t SINE_TABLE [16] = '{
        8'd128, 8'd176, 8'd218, 8'd246, 8'd255, 8'd246, 8'd218, 8'd176,
        8'd128, 8'd80,  8'd38,  8'd10,  8'd0,   8'd10,  8'd38,  8'd80
    };

    // Step periods of the lowest octave
    localparam period_t SEMITONE_PERIOD [12] = '{
        32'd1915712,  // C
        32'd1803586,  // C sharp
        32'd1702624,  // D
        32'd1607142,  // D sharp
        32'd1515152,  // E
        32'd1431731,  // F
        32'd1351351,  // F sharp
        32'd1275510,  // G
        32'd1204819,  // G sharp
        32'd1136364,  // A
        32'd1075268,  // A sharp
        32'd1017340   // B
    };

endpackage

`default_nettype wire

//--- verilog/uart_command_decoder.sv
`default_nettype none

module uart_command_decoder
    import synth_pkg::*;
#(
    parameter int CLKS_PER_BIT = 1250
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       uart_rx,
    output synth_cmd_t cmd
);

    localparam int TIMER_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [TIMER_W-1:0] BIT_LAST  = TIMER_W'(CLKS_PER_BIT - 1);
    localparam logic [TIMER_W-1:0] HALF_LAST = TIMER_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t          state;
    logic               rx_meta;
    logic               rx_sync;
    logic               rx_prev;
    logic [TIMER_W-1:0] timer;
    logic [2:0]         bit_idx;
    logic [7:0]         rx_byte;
    logic               byte_valid;  // One cycle after a good stop bit

    // Line idles high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= RX_IDLE;
            timer      <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            timer      <= timer + 1'b1;
            case (state)
                RX_IDLE: begin
                    timer <= '0;
                    if (rx_prev && !rx_sync) begin  // Falling edge opens a frame
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (timer == HALF_LAST) begin
                        timer <= '0;
                        state <= rx_sync ? RX_IDLE : RX_DATA;  // Glitch rejected
                    end
                end
                RX_DATA: begin
                    if (timer == BIT_LAST) begin
                        timer   <= '0;
                        bit_idx <= bit_idx + 1'b1;  // Wraps back to 0 after bit 7
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (timer == BIT_LAST) begin
                        byte_valid <= rx_sync;  // Framing error drops the byte
                        state      <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && timer == BIT_LAST) begin
            rx_byte <= {rx_sync, rx_byte[7:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd <= '{note: '0, wave: WAVE_TRIANGLE, noise_en: 1'b0};
        end else if (byte_valid) begin
            case (rx_byte)
                8'h54: cmd.wave <= WAVE_TRIANGLE;  // T
                8'h53: cmd.wave <= WAVE_SAWTOOTH;  // S
                8'h51: cmd.wave <= WAVE_SQUARE;    // Q
                8'h57: cmd.wave <= WAVE_SINE;      // W
                8'h4E: cmd.noise_en <= 1'b1;       // N
                8'h46: cmd.noise_en <= 1'b0;       // F
                default: begin
                    if (rx_byte inside {[8'h30:8'h39]}) begin
                        cmd.note <= note_t'(rx_byte - 8'h30);  // Digits give notes 0 to 9
                    end else if (rx_byte inside {[8'h41:8'h5A]}) begin
                        cmd.note <= note_t'(rx_byte - 8'h37);  // Capitals give 10 to 35
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(cmd) && cmd.wave inside {WAVE_TRIANGLE, WAVE_SAWTOOTH,
                                              WAVE_SQUARE, WAVE_SINE});

endmodule

`default_nettype wire

//--- verilog/pitch_divider.sv
`default_nettype none

module pitch_divider
    import synth_pkg::*;
#(
    parameter int PERIOD_SHIFT = 0
) (
    input  logic  clk,
    input  logic  rst_n,
    input  note_t note,
    output logic  step
);

    logic [1:0] octave;
    logic [3:0] semitone;
    period_t    base_period;
    period_t    shifted;
    period_t    period;
    period_t    count;
    note_t      note_q;  // Previous note, detects a change

    always_comb begin
        if (note < note_t'(12)) begin
            octave   = 2'd0;
            semitone = 4'(note);
        end else if (note < note_t'(24)) begin
            octave   = 2'd1;
            semitone = 4'(note - note_t'(12));
        end else begin
            octave   = 2'd2;
            semitone = 4'(note - note_t'(24));
        end
    end

    always_comb begin
        base_period = (semitone < 4'd12) ? SEMITONE_PERIOD[semitone] : SEMITONE_PERIOD[0];
        shifted     = base_period >> (int'(octave) + PERIOD_SHIFT);  // Halve once per octave
        period      = (shifted == '0) ? period_t'(1) : shifted;
    end

    // Counts period down to 0, so step fires every period plus 1 clocks
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count  <= '0;
            step   <= 1'b0;
            note_q <= '0;
        end else begin
            note_q <= note;
            step   <= 1'b0;
            if (note != note_q) begin
                count <= period;  // New note restarts the count
            end else if (count == '0) begin
                count <= period;
                step  <= 1'b1;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // Needs the period floor of 1
    assert property (@(posedge clk) disable iff (!rst_n) step |=> !step);

endmodule

`default_nettype wire

//--- verilog/waveform_generator.sv
`default_nettype none

module waveform_generator
    import synth_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    step,
    input  wave_t   wave,
    input  logic    noise_en,
    output sample_t sample
);

    logic [7:0]  phase;
    logic [15:0] lfsr;
    logic        lfsr_fb;
    sample_t     shape;

    // Shared by all four shapes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (step) begin
            phase <= phase + 1'b1;
        end
    end

    // Taps 16, 14, 13, 11
    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= NOISE_SEED;
        end else if (noise_en) begin
            lfsr <= {lfsr[14:0], lfsr_fb};
        end
    end

    always_comb begin
        case (wave)
            WAVE_TRIANGLE: begin
                // Falling half mirrors the rising half
                shape = {phase[7] ? ~phase[6:0] : phase[6:0], 1'b0};
            end
            WAVE_SAWTOOTH: shape = phase;
            WAVE_SQUARE:   shape = phase[7] ? 8'd255 : 8'd0;
            WAVE_SINE:     shape = SINE_TABLE[phase[7:4]];  // 16 points per period
            default:       shape = 8'd128;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample <= '0;
        end else begin
            sample <= noise_en ? lfsr[15:8] : shape;  // Noise replaces the tone
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) lfsr != '0);

endmodule

`default_nettype wire

//--- verilog/i2s_serializer.sv
`default_nettype none

module i2s_serializer
    import synth_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t sample,
    output logic    sck,
    output logic    ws,
    output logic    sd
);

    localparam int CNT_W = $clog2(I2S_WORD_BITS);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(I2S_WORD_BITS - 1);

    logic [CNT_W-1:0]         bit_cnt;
    logic [I2S_WORD_BITS-1:0] shift_word;
    logic [I2S_WORD_BITS-1:0] next_word;
    logic                     word_start;

    assign next_word  = {sample, sample};  // Same sample in both bytes
    assign word_start = sck && (bit_cnt == LAST_BIT);

    // Outputs move only while sck is about to fall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck     <= 1'b0;
            ws      <= 1'b0;
            sd      <= 1'b0;
            bit_cnt <= LAST_BIT;  // First falling edge opens a word
        end else begin
            sck <= ~sck;
            if (sck) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (word_start) begin
                    ws <= ~ws;
                    sd <= next_word[I2S_WORD_BITS-1];  // MSB first
                end else begin
                    sd <= shift_word[I2S_WORD_BITS-1];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_start) begin
            shift_word <= next_word << 1;
        end else if (sck) begin
            shift_word <= shift_word << 1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) $changed(ws) |-> bit_cnt == '0);

endmodule

`default_nettype wire

//--- verilog/synth_top.sv
`default_nettype none

module synth_top
    import synth_pkg::*;
#(
    parameter int CLKS_PER_BIT = 1250,
    parameter int PERIOD_SHIFT = 0
) (
    input  logic clk,
    input  logic rst_n,
    input  logic uart_rx,
    output logic i2s_sck,
    output logic i2s_ws,
    output logic i2s_sd
);

    synth_cmd_t cmd;     // Held until the next command
    logic       step;    // One pulse per step period
    sample_t    sample;

    uart_command_decoder #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) i_decoder (
        .clk    (clk),
        .rst_n  (rst_n),
        .uart_rx(uart_rx),
        .cmd    (cmd)
    );

    pitch_divider #(
        .PERIOD_SHIFT(PERIOD_SHIFT)
    ) i_divider (
        .clk  (clk),
        .rst_n(rst_n),
        .note (cmd.note),
        .step (step)
    );

    waveform_generator i_wave (
        .clk     (clk),
        .rst_n   (rst_n),
        .step    (step),
        .wave    (cmd.wave),
        .noise_en(cmd.noise_en),
        .sample  (sample)
    );

    i2s_serializer i_i2s (
        .clk   (clk),
        .rst_n (rst_n),
        .sample(sample),
        .sck   (i2s_sck),
        .ws    (i2s_ws),
        .sd    (i2s_sd)
    );

endmodule

`default_nettype wire

//--- testbench/tb_tasks.svh
// xorshift32 over the shared state
function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x   = rng;
    x   = x ^ (x << 13);
    x   = x ^ (x >> 17);
    x   = x ^ (x << 5);
    rng = x;
    return x;
endfunction

// 40 to 47 words per observe phase
function automatic int observe_len();
    return 40 + int'(xorshift() % 8);
endfunction

// Digits for notes 0 to 9, capitals above
function automatic logic [7:0] note_char(input int note);
    return (note < 10) ? 8'(8'h30 + note) : 8'(8'h41 + note - 10);
endfunction

// Letters F, N, Q, S, T and W are wave and noise commands
function automatic int random_note();
    int note;
    note = int'(xorshift() % 36);
    while (note_char(note) inside {8'h46, 8'h4E, 8'h51, 8'h53, 8'h54, 8'h57}) begin
        note = int'(xorshift() % 36);
    end
    return note;
endfunction

function automatic logic [7:0] wave_letter(input wave_t wave);
    logic [7:0] c;
    case (wave)
        WAVE_TRIANGLE: c = "T";
        WAVE_SAWTOOTH: c = "S";
        WAVE_SQUARE:   c = "Q";
        default:       c = "W";
    endcase
    return c;
endfunction

// Called on a falling edge, returns on a falling edge
task automatic hold_bit(input logic value);
    uart_rx = value;
    repeat (CLKS_PER_BIT) @(negedge clk);
endtask

task automatic send_byte(input logic [7:0] data, input logic stop_bit);
    @(negedge clk);
    hold_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
        hold_bit(data[i]);  // LSB first
    end
    hold_bit(stop_bit);
    hold_bit(1'b1);  // Idle gap
endtask

task automatic send_cmd(input logic [7:0] data);
    send_byte(data, 1'b1);
endtask

task automatic wait_word(output logic [7:0] value);
    int seen;
    seen = word_count;
    wait (word_count != seen);
    value = last_byte;
endtask

task automatic skip_words(input int n_words);
    logic [7:0] unused;
    repeat (n_words) wait_word(unused);
endtask

task automatic report_value(input string what, input string expected, input int actual);
    $display("ERR %s: %s expected %s actual %0d", test_name, what, expected, actual);
    test_errs++;
endtask

task automatic report_fail(input string msg);
    $display("%s: %s", test_name, msg);
    test_errs++;
endtask

task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
endtask

task automatic end_test();
    if (test_errs == 0) begin
        pass_count++;
        $display("test %s: ok", test_name);
    end else begin
        fail_count++;
        $display("test %s: %0d errors", test_name, test_errs);
    end
endtask

//--- testbench/tb_synth_top.sv
`default_nettype none

module tb_synth_top
    import synth_pkg::*;
();

    localparam int CLKS_PER_BIT   = 8;
    localparam int PERIOD_SHIFT   = 18;  // Both square halves within about 40 words
    localparam int RESET_CYCLES   = 8;
    localparam int WORD_CLKS      = 2 * I2S_WORD_BITS;
    localparam int BYTE_CLKS      = 11 * CLKS_PER_BIT + 1;  // Frame plus idle gap
    localparam int MAX_WORDS      = 47 + 2;  // Longest observe phase plus settling
    // Eight observe phases over six tests, plus UART bytes and reset
    localparam int TIMEOUT_CYCLES = 8 * MAX_WORDS * WORD_CLKS + 12 * BYTE_CLKS
                                    + 4 * RESET_CYCLES;
    localparam int MAX_SAW_STEP   = 20;

    logic        clk;
    logic        rst_n;
    logic        uart_rx;
    logic        i2s_sck;
    logic        i2s_ws;
    logic        i2s_sd;
    logic [31:0] rng         = 32'd33114;
    string       test_name   = "";
    int          test_errs   = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;
    int          cycle_count = 0;
    logic [15:0] mon_word    = '0;
    int          mon_bits    = 0;
    logic        mon_ws      = 1'b0;
    logic        mon_locked  = 1'b0;  // Set at the first ws edge
    int          word_count  = 0;
    logic [7:0]  last_byte   = '0;

    `include "tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    synth_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .PERIOD_SHIFT(PERIOD_SHIFT)
    ) i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .uart_rx(uart_rx),
        .i2s_sck(i2s_sck),
        .i2s_ws (i2s_ws),
        .i2s_sd (i2s_sd)
    );

    // Rebuilds words on rising sck, where sd and ws are stable
    always @(posedge i2s_sck) begin
        if (i2s_ws != mon_ws) begin
            if (mon_locked && mon_bits != I2S_WORD_BITS) begin
                report_value("bits per ws period", "16", mon_bits);
            end
            mon_locked = 1'b1;
            mon_bits   = 0;
        end
        mon_ws = i2s_ws;
        if (mon_locked) begin
            mon_word = {mon_word[14:0], i2s_sd};
            mon_bits++;
            if (mon_bits == I2S_WORD_BITS) begin
                if (mon_word[15:8] != mon_word[7:0]) begin
                    report_value("lower byte", $sformatf("%0d", mon_word[15:8]),
                                 mon_word[7:0]);
                end
                last_byte = mon_word[15:8];
                word_count++;
            end else if (mon_bits == I2S_WORD_BITS + 1) begin
                report_fail("ws did not toggle after 16 bits");
            end
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run exceeded %0d cycles in test %s", TIMEOUT_CYCLES, test_name);
        $display("TB FAILED");
        $finish;
    end

    task automatic check_shape(input wave_t wave, input int n_words);
        logic [7:0] b;
        logic [7:0] prev;
        logic [7:0] diff;
        logic       have_prev;
        logic       seen_low;
        logic       seen_high;
        logic       moved;
        logic       in_table;
        prev      = '0;
        have_prev = 1'b0;
        seen_low  = 1'b0;
        seen_high = 1'b0;
        moved     = 1'b0;
        for (int i = 0; i < n_words; i++) begin
            wait_word(b);
            case (wave)
                WAVE_SQUARE: begin
                    seen_low  = seen_low || (b == 8'd0);
                    seen_high = seen_high || (b == 8'd255);
                    if (b != 8'd0 && b != 8'd255) begin
                        report_value("square byte", "0 or 255", b);
                    end
                end
                WAVE_SINE: begin
                    in_table = 1'b0;
                    for (int k = 0; k < 16; k++) begin
                        in_table = in_table || (SINE_TABLE[k] == b);
                    end
                    if (!in_table) begin
                        report_value("sine byte", "a sine table entry", b);
                    end
                end
                WAVE_TRIANGLE: begin
                    if (b[0]) begin
                        report_value("triangle byte", "even", b);
                    end
                end
                default: begin
                    diff = b - prev;  // Modulo 256, so the wrap is a small step too
                    if (have_prev && b != prev) begin
                        moved = 1'b1;
                        if (diff > 8'(MAX_SAW_STEP)) begin
                            report_value("sawtooth step", "1 to 20", diff);
                        end
                    end
                    prev      = b;
                    have_prev = 1'b1;
                end
            endcase
        end
        if (wave == WAVE_SQUARE && !(seen_low && seen_high)) begin
            report_fail($sformatf("square wave missed 0 or 255 over %0d words", n_words));
        end
        if (wave == WAVE_SAWTOOTH && !moved) begin
            report_fail("sawtooth value never changed");
        end
    endtask

    task automatic check_noise(input int n_words);
        logic [7:0] b;
        int         mixed;
        mixed = 0;
        for (int i = 0; i < n_words; i++) begin
            wait_word(b);
            if (b != 8'd0 && b != 8'd255) begin
                mixed++;
            end
        end
        if (mixed == 0) begin
            report_fail($sformatf("noise gave only 0 and 255 over %0d words", n_words));
        end
    endtask

    initial begin
        int note;
        rst_n   = 1'b0;
        uart_rx = 1'b1;  // Idle line

        start_test("reset_framing");
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (i2s_sck !== 1'b0 || i2s_ws !== 1'b0 || i2s_sd !== 1'b0) begin
                report_fail("I2S outputs are not low during reset");
            end
        end
        rst_n = 1'b1;
        @(posedge i2s_sck);
        if (i2s_ws !== 1'b0 || i2s_sd !== 1'b0) begin
            report_fail("ws or sd moved before the first bit clock");
        end
        skip_words(8);  // Monitor checks the framing
        end_test();

        start_test("square_note");
        note = random_note();
        send_cmd(wave_letter(WAVE_SQUARE));
        send_cmd(note_char(note));
        skip_words(2);
        check_shape(WAVE_SQUARE, observe_len());
        end_test();

        start_test("sine");
        send_cmd(wave_letter(WAVE_SINE));
        skip_words(2);
        check_shape(WAVE_SINE, observe_len());
        end_test();

        start_test("triangle");
        send_cmd(wave_letter(WAVE_TRIANGLE));
        skip_words(2);
        check_shape(WAVE_TRIANGLE, observe_len());
        end_test();

        start_test("sawtooth_ignore");
        note = random_note();
        send_cmd(wave_letter(WAVE_SAWTOOTH));
        send_cmd(note_char(note));
        skip_words(2);
        check_shape(WAVE_SAWTOOTH, observe_len());
        send_cmd("a");                               // Lowercase is no command
        send_byte(wave_letter(WAVE_SQUARE), 1'b0);   // Low stop bit drops the byte
        skip_words(2);
        check_shape(WAVE_SAWTOOTH, observe_len());
        end_test();

        start_test("noise");
        send_cmd(wave_letter(WAVE_SQUARE));
        send_cmd("N");
        skip_words(2);
        check_noise(observe_len());
        send_cmd("F");
        skip_words(2);
        check_shape(WAVE_SQUARE, observe_len());
        end_test();

        $display("tests: %0d ok, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+testbench
verilog/synth_pkg.sv
verilog/uart_command_decoder.sv
verilog/pitch_divider.sv
verilog/waveform_generator.sv
verilog/i2s_serializer.sv
verilog/synth_top.sv
testbench/tb_synth_top.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_synth_top -f all.f -Mdir obj_dir
	./obj_dir/Vtb_synth_top | tee /dev/stderr | grep '^TB PASSED$$' > /dev/null

clean:
	rm -rf obj_dir
